/* all.f */
+incdir+design
design/aluPkg.sv
design/opDispatcher.sv
design/aluLane.sv
design/resultCollector.sv
design/aluCluster.sv
verification/aluCluster_chk.sv
verification/aluClusterTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = aluClusterTb
FILELIST = all.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

/* verification/aluClusterTb.sv */
`default_nettype none

`include "alu_config.svh"

module aluClusterTb;

  logic                       clk;
  logic                       reset;
  logic                       reqValid;
  aluPkg::aluOp_e             reqOp;
  logic [`ALU_DATA_WIDTH-1:0] reqA;
  logic [`ALU_DATA_WIDTH-1:0] reqB;
  logic                       reqCarryIn;
  logic                       reqCredit;
  logic                       rspCredit;
  logic                       rspValid;
  logic [`ALU_DATA_WIDTH-1:0] rspResult;
  aluPkg::aluFlags_t          rspFlags;

  // Stimulus table
  string          rowName[$];
  aluPkg::aluOp_e rowOp[$];
  logic [31:0]    rowA[$];
  logic [31:0]    rowB[$];
  logic           rowCin[$];
  logic [31:0]    expResult[$];
  logic [4:0]     expFlags[$];

  int numRows;
  int upCredits;
  int grantedCredits;
  int rspCount;
  int passCount;
  int errorCount;

  aluCluster dut (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .reqOp      (reqOp),
    .reqA       (reqA),
    .reqB       (reqB),
    .reqCarryIn (reqCarryIn),
    .reqCredit  (reqCredit),
    .rspCredit  (rspCredit),
    .rspValid   (rspValid),
    .rspResult  (rspResult),
    .rspFlags   (rspFlags)
  );

  bind aluCluster aluCluster_chk chk (
    .clk       (clk),
    .reset     (reset),
    .reqCredit (reqCredit),
    .rspCredit (rspCredit),
    .rspValid  (rspValid),
    .rspResult (rspResult),
    .rspFlags  (rspFlags)
  );

  task automatic addRow(string name, aluPkg::aluOp_e op, logic [31:0] a, logic [31:0] b,
                        logic cin, logic [31:0] result, logic [4:0] flags);
    rowName.push_back(name);
    rowOp.push_back(op);
    rowA.push_back(a);
    rowB.push_back(b);
    rowCin.push_back(cin);
    expResult.push_back(result);
    expFlags.push_back(flags);
  endtask

  // One row per case with name, op, A, B, carry-in, result and NZCVQ flags
  task automatic fillTable();
    addRow("add",      aluPkg::opAdd,  32'h00000005, 32'h00000007, 1, 32'h0000000C, 5'b00000);
    addRow("addOvf",   aluPkg::opAdd,  32'h7FFFFFFF, 32'h00000001, 0, 32'h80000000, 5'b10010);
    addRow("addWrap",  aluPkg::opAdd,  32'hFFFFFFFF, 32'h00000001, 0, 32'h00000000, 5'b01100);
    addRow("adc",      aluPkg::opAdc,  32'h00000010, 32'h00000020, 1, 32'h00000031, 5'b00000);
    addRow("adcWrap",  aluPkg::opAdc,  32'hFFFFFFFF, 32'h00000000, 1, 32'h00000000, 5'b01100);
    addRow("cmn",      aluPkg::opCmn,  32'h80000000, 32'h80000000, 0, 32'h00000000, 5'b01110);
    addRow("sub",      aluPkg::opSub,  32'h0000000A, 32'h00000003, 0, 32'h00000007, 5'b00100);
    addRow("subNeg",   aluPkg::opSub,  32'h00000000, 32'h00000001, 1, 32'hFFFFFFFF, 5'b10000);
    addRow("subOvf",   aluPkg::opSub,  32'h80000000, 32'h00000001, 0, 32'h7FFFFFFF, 5'b00110);
    addRow("sbcBorrow", aluPkg::opSbc, 32'h0000000A, 32'h00000003, 0, 32'h00000006, 5'b00100);
    addRow("sbcZero",  aluPkg::opSbc,  32'h00000005, 32'h00000005, 1, 32'h00000000, 5'b01100);
    addRow("sbcUnder", aluPkg::opSbc,  32'h00000005, 32'h00000005, 0, 32'hFFFFFFFF, 5'b10000);
    addRow("rsb",      aluPkg::opRsb,  32'h00000003, 32'h0000000A, 0, 32'h00000007, 5'b00100);
    addRow("rsbNeg",   aluPkg::opRsb,  32'h0000000A, 32'h00000003, 1, 32'hFFFFFFF9, 5'b10000);
    addRow("cmpEq",    aluPkg::opCmp,  32'h00001234, 32'h00001234, 0, 32'h00000000, 5'b01100);
    addRow("cmpLess",  aluPkg::opCmp,  32'h00000001, 32'h00000002, 0, 32'hFFFFFFFF, 5'b10000);
    addRow("qaddMax",  aluPkg::opQadd, 32'h7FFFFFFF, 32'h00000001, 0, 32'h7FFFFFFF, 5'b00011);
    addRow("qaddMin",  aluPkg::opQadd, 32'h80000000, 32'hFFFFFFFF, 1, 32'h80000000, 5'b10111);
    addRow("qaddOk",   aluPkg::opQadd, 32'h00000064, 32'h000000C8, 0, 32'h0000012C, 5'b00000);
    addRow("qsubMax",  aluPkg::opQsub, 32'h7FFFFFFF, 32'hFFFFFFFF, 0, 32'h7FFFFFFF, 5'b00011);
    addRow("qsubMin",  aluPkg::opQsub, 32'h80000000, 32'h00000001, 0, 32'h80000000, 5'b10011);
    addRow("qsubOk",   aluPkg::opQsub, 32'h00000032, 32'h00000050, 1, 32'hFFFFFFE2, 5'b10100);
    addRow("and",      aluPkg::opAnd,  32'hF0F0F0F0, 32'hFF00FF00, 1, 32'hF000F000, 5'b10100);
    addRow("bic",      aluPkg::opBic,  32'hFFFFFFFF, 32'h0000FFFF, 0, 32'hFFFF0000, 5'b10000);
    addRow("orr",      aluPkg::opOrr,  32'h12340000, 32'h00005678, 1, 32'h12345678, 5'b00100);
    addRow("orn",      aluPkg::opOrn,  32'h00000000, 32'hFFFFFFFF, 0, 32'h00000000, 5'b01000);
    addRow("eor",      aluPkg::opEor,  32'hAAAAAAAA, 32'h55555555, 0, 32'hFFFFFFFF, 5'b10000);
    addRow("tst",      aluPkg::opTst,  32'h0000000F, 32'h000000F0, 1, 32'h00000000, 5'b01100);
    addRow("teq",      aluPkg::opTeq,  32'h00001234, 32'h00001234, 0, 32'h00000000, 5'b01000);
    addRow("mov",      aluPkg::opMov,  32'h00000000, 32'h80000001, 1, 32'h80000001, 5'b10100);
    addRow("mulZero",  aluPkg::opMul,  32'h00010000, 32'h00010000, 0, 32'h00000000, 5'b01000);
    addRow("mulNeg",   aluPkg::opMul,  32'h00000007, 32'hFFFFFFFF, 1, 32'hFFFFFFF9, 5'b10100);
    addRow("lsl",      aluPkg::opLsl,  32'h80000001, 32'h00000001, 0, 32'h00000002, 5'b00100);
    addRow("lslZero",  aluPkg::opLsl,  32'h80000001, 32'h00000000, 1, 32'h80000001, 5'b10100);
    addRow("lslUpper", aluPkg::opLsl,  32'h00000001, 32'hFFFFFF04, 1, 32'h00000010, 5'b00000);
    addRow("lsr",      aluPkg::opLsr,  32'h00000003, 32'h00000001, 0, 32'h00000001, 5'b00100);
    addRow("lsr31",    aluPkg::opLsr,  32'h80000000, 32'h0000001F, 1, 32'h00000001, 5'b00000);
    addRow("asr",      aluPkg::opAsr,  32'h80000000, 32'h00000004, 1, 32'hF8000000, 5'b10000);
    addRow("asrOdd",   aluPkg::opAsr,  32'hFFFFFFF1, 32'h00000001, 0, 32'hFFFFFFF8, 5'b10100);
    addRow("ror",      aluPkg::opRor,  32'h00000001, 32'h00000001, 0, 32'h80000000, 5'b10100);
    addRow("ror8",     aluPkg::opRor,  32'h12345678, 32'hABCDEF08, 1, 32'h78123456, 5'b00000);
    addRow("rrx",      aluPkg::opRrx,  32'h00000003, 32'h00000000, 1, 32'h80000001, 5'b10100);
    addRow("rrxZero",  aluPkg::opRrx,  32'h00000002, 32'h00000000, 0, 32'h00000001, 5'b00000);
    numRows = rowName.size();
  endtask

  // Send each row while an upstream credit is held
  task automatic sendRows();
    for (int r = 0; r < numRows; r++) begin
      do begin
        @(posedge clk);
        #1;
        reqValid = 1'b0;
      end while (upCredits == 0);
      reqValid   = 1'b1;
      reqOp      = rowOp[r];
      reqA       = rowA[r];
      reqB       = rowB[r];
      reqCarryIn = rowCin[r];
      upCredits--;
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic checkResponse();
    logic [4:0] gotFlags;
    gotFlags = rspFlags;
    grantedCredits--;
    if (rspCount >= numRows) begin
      $display("Extra response %h arrived after all %0d rows", rspResult, numRows);
      errorCount++;
    end else begin
      assert (rspResult == expResult[rspCount] && gotFlags == expFlags[rspCount]) begin
        $display("ok       %s result %h flags %b", rowName[rspCount], rspResult, gotFlags);
        passCount++;
      end else begin
        $display("MISMATCH %s expected %h flags %b actual %h flags %b", rowName[rspCount],
                 expResult[rspCount], expFlags[rspCount], rspResult, gotFlags);
        errorCount++;
      end
      rspCount++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (reqCredit) begin
        upCredits++;
      end
      if (rspValid) begin
        checkResponse();
      end
    end
  end

  // Random response credits up to the most the cluster may hold
  initial begin
    void'($urandom(94));
    @(negedge reset);
    forever begin
      @(posedge clk);
      #1;
      if (grantedCredits < `ALU_OUT_CREDITS_MAX && ($urandom % 3) == 0) begin
        rspCredit = 1'b1;
        grantedCredits++;
      end else begin
        rspCredit = 1'b0;
      end
    end
  end

  initial begin
    reset          = 1'b1;
    reqValid       = 1'b0;
    reqOp          = aluPkg::opAdd;
    reqA           = '0;
    reqB           = '0;
    reqCarryIn     = 1'b0;
    rspCredit      = 1'b0;
    upCredits      = `ALU_IN_DEPTH;
    grantedCredits = 0;
    rspCount       = 0;
    passCount      = 0;
    errorCount     = 0;
    fillTable();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    fork
      begin
        repeat (numRows * 40 + 200) @(posedge clk);
        $display("Timeout with %0d of %0d responses missing", numRows - rspCount, numRows);
        $display("sim failed");
        $finish;
      end
    join_none
    sendRows();
    wait (rspCount == numRows);
    // Leave time for any stray extra response
    repeat (20) @(posedge clk);
    $display("rows %0d passed %0d failed %0d", numRows, passCount, errorCount);
    if (errorCount == 0 && passCount == numRows) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/aluCluster_chk.sv */
`default_nettype none

`include "alu_config.svh"

module aluCluster_chk (
  input wire logic                       clk,
  input wire logic                       reset,
  input wire logic                       reqCredit,
  input wire logic                       rspCredit,
  input wire logic                       rspValid,
  input wire logic [`ALU_DATA_WIDTH-1:0] rspResult,
  input wire aluPkg::aluFlags_t          rspFlags
);

  // Response credits the cluster holds as seen at the port
  int heldCredits;

  always_ff @(posedge clk) begin
    if (reset) begin
      heldCredits <= 0;
    end else begin
      heldCredits <= heldCredits + int'(rspCredit) - int'(rspValid);
    end
  end

  noOverdraw: assert property (@(posedge clk) disable iff (reset)
    rspValid |-> heldCredits > 0)
    else $error("response sent while no response credit was held");

  creditBound: assert property (@(posedge clk) disable iff (reset)
    heldCredits <= `ALU_OUT_CREDITS_MAX)
    else $error("more response credits outstanding than allowed");

  // Upstream credits only return once reset has been released
  quietReset: assert property (@(posedge clk)
    reset && $past(reset) |-> !reqCredit)
    else $error("request credit returned during reset");

  // Zero and negative follow the returned word and are never both set
  flagsConsistent: assert property (@(posedge clk) disable iff (reset)
    rspValid |-> (rspFlags.zero == (rspResult == '0)) &&
                 (rspFlags.negative == rspResult[`ALU_DATA_WIDTH-1]))
    else $error("zero or negative flag does not match the returned word");

endmodule

`default_nettype wire

/* design/aluCluster.sv */
`default_nettype none

`include "alu_config.svh"

module aluCluster (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       reqValid,
  input  wire aluPkg::aluOp_e             reqOp,
  input  wire logic [`ALU_DATA_WIDTH-1:0] reqA,
  input  wire logic [`ALU_DATA_WIDTH-1:0] reqB,
  input  wire logic                       reqCarryIn,
  output logic                            reqCredit,
  input  wire logic                       rspCredit,
  output logic                            rspValid,
  output logic [`ALU_DATA_WIDTH-1:0]      rspResult,
  output aluPkg::aluFlags_t               rspFlags
);

  // Dispatcher to lanes, data shared by all lanes
  logic [`ALU_LANES-1:0]      laneValid;
  aluPkg::aluOp_e             laneOp;
  logic [`ALU_DATA_WIDTH-1:0] laneA;
  aluPkg::operandB_u          laneB;
  logic                       laneCarryIn;

  // Lanes to collector
  logic [`ALU_LANES-1:0]      resultValid;
  logic [`ALU_DATA_WIDTH-1:0] resultWord  [`ALU_LANES];
  aluPkg::aluFlags_t          resultFlags [`ALU_LANES];
  logic [`ALU_LANES-1:0]      resultPop;
  logic [`ALU_LANES-1:0]      laneCredit;

  opDispatcher dispatcher (
    .clk         (clk),
    .reset       (reset),
    .reqValid    (reqValid),
    .reqOp       (reqOp),
    .reqA        (reqA),
    .reqB        (reqB),
    .reqCarryIn  (reqCarryIn),
    .laneCredit  (laneCredit),
    .reqCredit   (reqCredit),
    .laneValid   (laneValid),
    .laneOp      (laneOp),
    .laneA       (laneA),
    .laneB       (laneB),
    .laneCarryIn (laneCarryIn)
  );

  for (genvar i = 0; i < `ALU_LANES; i++) begin : genLane
    aluLane lane (
      .clk         (clk),
      .reset       (reset),
      .laneValid   (laneValid[i]),
      .laneOp      (laneOp),
      .laneA       (laneA),
      .laneB       (laneB),
      .laneCarryIn (laneCarryIn),
      .resultPop   (resultPop[i]),
      .resultValid (resultValid[i]),
      .resultWord  (resultWord[i]),
      .resultFlags (resultFlags[i])
    );
  end

  resultCollector collector (
    .clk         (clk),
    .reset       (reset),
    .resultValid (resultValid),
    .resultWord  (resultWord),
    .resultFlags (resultFlags),
    .rspCredit   (rspCredit),
    .resultPop   (resultPop),
    .laneCredit  (laneCredit),
    .rspValid    (rspValid),
    .rspResult   (rspResult),
    .rspFlags    (rspFlags)
  );

endmodule

`default_nettype wire

/* design/resultCollector.sv */
`default_nettype none

`include "alu_config.svh"

module resultCollector (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic [`ALU_LANES-1:0]      resultValid,
  input  wire logic [`ALU_DATA_WIDTH-1:0] resultWord [`ALU_LANES],
  input  wire aluPkg::aluFlags_t          resultFlags [`ALU_LANES],
  input  wire logic                       rspCredit,
  output logic [`ALU_LANES-1:0]           resultPop,
  output logic [`ALU_LANES-1:0]           laneCredit,
  output logic                            rspValid,
  output logic [`ALU_DATA_WIDTH-1:0]      rspResult,
  output aluPkg::aluFlags_t               rspFlags
);

  localparam int laneWidth   = $clog2(`ALU_LANES);
  localparam int creditWidth = $clog2(`ALU_OUT_CREDITS_MAX + 1);
  localparam int lastLane    = `ALU_LANES - 1;

  logic [laneWidth-1:0]   drainPtr;
  logic [creditWidth-1:0] outCredits;
  logic [creditWidth-1:0] spareCredits;
  logic                   pop;

  // A response in flight still holds its credit until this cycle ends
  assign spareCredits = outCredits - rspValid;
  assign pop          = resultValid[drainPtr] && (spareCredits != '0);

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      resultPop[i] = pop && (drainPtr == laneWidth'(i));
    end
  end

  // Each popped slot goes straight back to the dispatcher
  assign laneCredit = resultPop;

  always_ff @(posedge clk) begin
    if (pop) begin
      rspResult <= resultWord[drainPtr];
      rspFlags  <= resultFlags[drainPtr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= pop;
    end
  end

  // Same lane order as the dispatcher keeps responses in request order
  always_ff @(posedge clk) begin
    if (reset) begin
      drainPtr <= '0;
    end else if (pop) begin
      drainPtr <= (drainPtr == laneWidth'(lastLane)) ? '0 : drainPtr + 1'b1;
    end
  end

  // Credit is spent in the cycle rspValid is high
  always_ff @(posedge clk) begin
    if (reset) begin
      outCredits <= '0;
    end else begin
      outCredits <= outCredits + rspCredit - rspValid;
    end
  end

endmodule

`default_nettype wire

/* design/aluLane.sv */
`default_nettype none

`include "alu_config.svh"

module aluLane (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       laneValid,
  input  wire aluPkg::aluOp_e             laneOp,
  input  wire logic [`ALU_DATA_WIDTH-1:0] laneA,
  input  wire aluPkg::operandB_u          laneB,
  input  wire logic                       laneCarryIn,
  input  wire logic                       resultPop,
  output logic                            resultValid,
  output logic [`ALU_DATA_WIDTH-1:0]      resultWord,
  output aluPkg::aluFlags_t               resultFlags
);

  localparam int dataWidth  = `ALU_DATA_WIDTH;
  localparam int slotWidth  = $clog2(`ALU_LANE_DEPTH);
  localparam int countWidth = $clog2(`ALU_LANE_DEPTH + 1);
  localparam int lastSlot   = `ALU_LANE_DEPTH - 1;
  localparam logic [dataWidth-1:0] satMax = {1'b0, {(dataWidth-1){1'b1}}};
  localparam logic [dataWidth-1:0] satMin = {1'b1, {(dataWidth-1){1'b0}}};

  // Stage 1 arithmetic
  logic                 addCarryIn;
  logic                 subCarryIn;
  logic [dataWidth-1:0] subMin;
  logic [dataWidth-1:0] subSub;
  logic [dataWidth:0]   addSum;
  logic [dataWidth:0]   subDiff;
  logic [dataWidth-1:0] product;

  // Stage 1 registers
  logic                 s1Valid;
  aluPkg::aluOp_e       s1Op;
  logic [dataWidth-1:0] s1A;
  aluPkg::operandB_u    s1B;
  logic                 s1CarryIn;
  logic [dataWidth:0]   s1Sum;
  logic [dataWidth:0]   s1Diff;
  logic [dataWidth-1:0] s1Prod;

  // Stage 2 select
  logic [4:0]             shiftAmt;
  logic                   shiftZero;
  logic [dataWidth:0]     lslExt;
  logic [dataWidth:0]     lsrExt;
  logic [dataWidth:0]     asrExt;
  logic [2*dataWidth-1:0] rorExt;
  logic                   addOvf;
  logic                   subOvf;
  logic                   subMinSign;
  logic [dataWidth-1:0]   s2Result;
  logic                   s2Carry;
  logic                   s2Overflow;
  logic                   s2Saturated;
  aluPkg::aluFlags_t      s2Flags;

  // Result queue
  logic [dataWidth-1:0]   qWord  [`ALU_LANE_DEPTH];
  aluPkg::aluFlags_t      qFlags [`ALU_LANE_DEPTH];
  logic [slotWidth-1:0]   wrSlot;
  logic [slotWidth-1:0]   rdSlot;
  logic [countWidth-1:0]  qCount;

  // RSB swaps the operands, SBC borrows when carry-in is low
  always_comb begin
    addCarryIn = (laneOp == aluPkg::opAdc) ? laneCarryIn : 1'b0;
    subCarryIn = (laneOp == aluPkg::opSbc) ? laneCarryIn : 1'b1;
    subMin     = (laneOp == aluPkg::opRsb) ? laneB.data : laneA;
    subSub     = (laneOp == aluPkg::opRsb) ? laneA : laneB.data;
    addSum     = {1'b0, laneA} + {1'b0, laneB.data} + {{dataWidth{1'b0}}, addCarryIn};
    subDiff    = {1'b0, subMin} + {1'b0, ~subSub} + {{dataWidth{1'b0}}, subCarryIn};
    product    = laneA * laneB.data;
  end

  always_ff @(posedge clk) begin
    s1Op      <= laneOp;
    s1A       <= laneA;
    s1B       <= laneB;
    s1CarryIn <= laneCarryIn;
    s1Sum     <= addSum;
    s1Diff    <= subDiff;
    s1Prod    <= product;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= laneValid;
    end
  end

  // Extra low or high bit catches the last bit shifted out
  assign shiftAmt   = s1B.shift.amount;
  assign shiftZero  = (shiftAmt == 5'd0);
  assign lslExt     = {1'b0, s1A} << shiftAmt;
  assign lsrExt     = {s1A, 1'b0} >> shiftAmt;
  assign asrExt     = $signed({s1A, 1'b0}) >>> shiftAmt;
  assign rorExt     = {s1A, s1A} >> shiftAmt;
  assign subMinSign = (s1Op == aluPkg::opRsb) ? s1B.data[dataWidth-1] : s1A[dataWidth-1];

  // Signed overflow: operand signs versus result sign
  assign addOvf = (s1A[dataWidth-1] == s1B.data[dataWidth-1]) &&
                  (s1Sum[dataWidth-1] != s1A[dataWidth-1]);
  assign subOvf = (s1A[dataWidth-1] != s1B.data[dataWidth-1]) &&
                  (s1Diff[dataWidth-1] != subMinSign);

  always_comb begin
    s2Result    = '0;
    s2Carry     = s1CarryIn;
    s2Overflow  = 1'b0;
    s2Saturated = 1'b0;
    case (s1Op)
      aluPkg::opAdd, aluPkg::opAdc, aluPkg::opCmn: begin
        s2Result   = s1Sum[dataWidth-1:0];
        s2Carry    = s1Sum[dataWidth];
        s2Overflow = addOvf;
      end
      aluPkg::opQadd: begin
        s2Result    = addOvf ? (s1A[dataWidth-1] ? satMin : satMax) : s1Sum[dataWidth-1:0];
        s2Overflow  = addOvf;
        s2Saturated = addOvf;
      end
      aluPkg::opSub, aluPkg::opSbc, aluPkg::opRsb, aluPkg::opCmp: begin
        s2Result   = s1Diff[dataWidth-1:0];
        s2Carry    = s1Diff[dataWidth];
        s2Overflow = subOvf;
      end
      aluPkg::opQsub: begin
        s2Result    = subOvf ? (s1A[dataWidth-1] ? satMin : satMax) : s1Diff[dataWidth-1:0];
        s2Overflow  = subOvf;
        s2Saturated = subOvf;
      end
      aluPkg::opMul:                 s2Result = s1Prod;
      aluPkg::opAnd, aluPkg::opTst:  s2Result = s1A & s1B.data;
      aluPkg::opBic:                 s2Result = s1A & ~s1B.data;
      aluPkg::opOrr:                 s2Result = s1A | s1B.data;
      aluPkg::opOrn:                 s2Result = s1A | ~s1B.data;
      aluPkg::opEor, aluPkg::opTeq:  s2Result = s1A ^ s1B.data;
      aluPkg::opMov:                 s2Result = s1B.data;
      aluPkg::opLsl: begin
        s2Result = lslExt[dataWidth-1:0];
        s2Carry  = shiftZero ? s1CarryIn : lslExt[dataWidth];
      end
      aluPkg::opLsr: begin
        s2Result = lsrExt[dataWidth:1];
        s2Carry  = shiftZero ? s1CarryIn : lsrExt[0];
      end
      aluPkg::opAsr: begin
        s2Result = asrExt[dataWidth:1];
        s2Carry  = shiftZero ? s1CarryIn : asrExt[0];
      end
      aluPkg::opRor: begin
        s2Result = rorExt[dataWidth-1:0];
        s2Carry  = shiftZero ? s1CarryIn : rorExt[dataWidth-1];
      end
      aluPkg::opRrx: begin
        s2Result = {s1CarryIn, s1A[dataWidth-1:1]};
        s2Carry  = s1A[0];
      end
      default: s2Result = '0;
    endcase
  end

  always_comb begin
    s2Flags.negative  = s2Result[dataWidth-1];
    s2Flags.zero      = (s2Result == '0);
    s2Flags.carry     = s2Carry;
    s2Flags.overflow  = s2Overflow;
    s2Flags.saturated = s2Saturated;
  end

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      qWord[wrSlot]  <= s2Result;
      qFlags[wrSlot] <= s2Flags;
    end
  end

  // Dispatcher credits keep the queue from overflowing
  always_ff @(posedge clk) begin
    if (reset) begin
      wrSlot <= '0;
      rdSlot <= '0;
      qCount <= '0;
    end else begin
      if (s1Valid) begin
        wrSlot <= (wrSlot == slotWidth'(lastSlot)) ? '0 : wrSlot + 1'b1;
      end
      if (resultPop) begin
        rdSlot <= (rdSlot == slotWidth'(lastSlot)) ? '0 : rdSlot + 1'b1;
      end
      qCount <= qCount + s1Valid - resultPop;
    end
  end

  assign resultValid = (qCount != '0);
  assign resultWord  = qWord[rdSlot];
  assign resultFlags = qFlags[rdSlot];

endmodule

`default_nettype wire

/* design/opDispatcher.sv */
`default_nettype none

`include "alu_config.svh"

module opDispatcher (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       reqValid,
  input  wire aluPkg::aluOp_e             reqOp,
  input  wire logic [`ALU_DATA_WIDTH-1:0] reqA,
  input  wire logic [`ALU_DATA_WIDTH-1:0] reqB,
  input  wire logic                       reqCarryIn,
  input  wire logic [`ALU_LANES-1:0]      laneCredit,
  output logic                            reqCredit,
  output logic [`ALU_LANES-1:0]           laneValid,
  output aluPkg::aluOp_e                  laneOp,
  output logic [`ALU_DATA_WIDTH-1:0]      laneA,
  output aluPkg::operandB_u               laneB,
  output logic                            laneCarryIn
);

  localparam int slotWidth   = $clog2(`ALU_IN_DEPTH);
  localparam int countWidth  = $clog2(`ALU_IN_DEPTH + 1);
  localparam int laneWidth   = $clog2(`ALU_LANES);
  localparam int creditWidth = $clog2(`ALU_LANE_DEPTH + 1);
  localparam int lastSlot    = `ALU_IN_DEPTH - 1;
  localparam int lastLane    = `ALU_LANES - 1;

  // Request queue
  aluPkg::aluOp_e             qOp    [`ALU_IN_DEPTH];
  logic [`ALU_DATA_WIDTH-1:0] qA     [`ALU_IN_DEPTH];
  aluPkg::operandB_u          qB     [`ALU_IN_DEPTH];
  logic                       qCarry [`ALU_IN_DEPTH];
  logic [slotWidth-1:0]       wrSlot;
  logic [slotWidth-1:0]       rdSlot;
  logic [countWidth-1:0]      qCount;

  // Free result slots in each lane
  logic [creditWidth-1:0]     laneCredits [`ALU_LANES];
  logic [laneWidth-1:0]       rrPtr;
  logic                       issue;

  // Stall on a lane without credit, never skip it
  assign issue     = (qCount != '0) && (laneCredits[rrPtr] != '0);
  assign reqCredit = issue;

  // Shared data wires, qualified per lane by laneValid
  assign laneOp      = qOp[rdSlot];
  assign laneA       = qA[rdSlot];
  assign laneB       = qB[rdSlot];
  assign laneCarryIn = qCarry[rdSlot];

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      laneValid[i] = issue && (rrPtr == laneWidth'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) begin
      qOp[wrSlot]     <= reqOp;
      qA[wrSlot]      <= reqA;
      qB[wrSlot].data <= reqB;
      qCarry[wrSlot]  <= reqCarryIn;
    end
  end

  // Upstream credits guarantee a free slot on every reqValid
  always_ff @(posedge clk) begin
    if (reset) begin
      wrSlot <= '0;
      rdSlot <= '0;
      qCount <= '0;
    end else begin
      if (reqValid) begin
        wrSlot <= (wrSlot == slotWidth'(lastSlot)) ? '0 : wrSlot + 1'b1;
      end
      if (issue) begin
        rdSlot <= (rdSlot == slotWidth'(lastSlot)) ? '0 : rdSlot + 1'b1;
      end
      qCount <= qCount + reqValid - issue;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        laneCredits[i] <= creditWidth'(`ALU_LANE_DEPTH);
      end
      rrPtr <= '0;
    end else begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        laneCredits[i] <= laneCredits[i] + laneCredit[i] - laneValid[i];
      end
      if (issue) begin
        rrPtr <= (rrPtr == laneWidth'(lastLane)) ? '0 : rrPtr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/aluPkg.sv */
`default_nettype none

`include "alu_config.svh"

package aluPkg;

  // Opcode encodings of the single-cycle ALU
  // 01000 to 01111 belong to the MAC and divide units
  typedef enum logic [4:0] {
    opAdd  = 5'b00000,
    opAdc  = 5'b00001,
    opQadd = 5'b00010,
    opSub  = 5'b00011,
    opSbc  = 5'b00100,
    opRsb  = 5'b00101,
    opQsub = 5'b00110,
    opMul  = 5'b00111,
    opAnd  = 5'b10000,
    opBic  = 5'b10001,
    opOrr  = 5'b10010,
    opOrn  = 5'b10011,
    opEor  = 5'b10100,
    opCmn  = 5'b10101,
    opTst  = 5'b10110,
    opTeq  = 5'b10111,
    opCmp  = 5'b11000,
    opMov  = 5'b11001,
    opLsr  = 5'b11010,
    opAsr  = 5'b11011,
    opLsl  = 5'b11100,
    opRor  = 5'b11101,
    opRrx  = 5'b11110
  } aluOp_e;

  // Status flags, MSB first
  typedef struct packed {
    logic negative;
    logic zero;
    logic carry;
    logic overflow;
    logic saturated;
  } aluFlags_t;

  // Shift descriptor view of operand B
  typedef struct packed {
    logic [`ALU_DATA_WIDTH-6:0] ignored;
    logic [4:0]                 amount;
  } shiftDesc_t;

  // Operand B is either a plain word or a shift amount
  typedef union packed {
    logic [`ALU_DATA_WIDTH-1:0] data;
    shiftDesc_t                 shift;
  } operandB_u;

endpackage

`default_nettype wire

/* design/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
// Flag generation relies on this being 32
`define ALU_DATA_WIDTH 32

// Number of pipelined lanes, 2, 4 or 8
`define ALU_LANES 4

// Dispatcher request queue depth, also the upstream credits after reset
`define ALU_IN_DEPTH 4

// Per-lane result queue depth, also the dispatcher credits per lane
`define ALU_LANE_DEPTH 4

// Upper bound on outstanding response credits
`define ALU_OUT_CREDITS_MAX 8

`endif
